//--- design/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_EVICT,
        ST_WAIT_DRAIN,
        ST_REFILL,
        ST_FINISH
    } ctrl_state_t;

    // dirty victim on its way to memory
    typedef struct packed {
        logic [ADDR_W-3:0] waddr;
        logic [DATA_W-1:0] data;
    } evict_t;

    // byte lanes touched by an access of this size at this offset
    function automatic logic [3:0] apply_size(size_t size, logic [1:0] off);
        logic [3:0] mask;
        case (size)
            SIZE_BYTE: mask = 4'b0001 << off;
            SIZE_HALF: mask = off[1] ? 4'b1100 : 4'b0011;
            default:   mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

//--- design/cache_way.sv
module cache_way #(
    parameter int INDEX_BITS = 4
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [cache_pkg::ADDR_W-1:0]             addr,
    input  cache_pkg::size_t                         size,
    input  logic [cache_pkg::DATA_W-1:0]             wdata,
    input  logic                                     we,
    input  logic                                     fill,
    input  logic                                     store,
    output logic                                     hit,
    output logic                                     dirty,
    output logic [cache_pkg::ADDR_W-3-INDEX_BITS:0]  victim_tag,
    output logic [cache_pkg::DATA_W-1:0]             line_data,
    output logic [cache_pkg::DATA_W-1:0]             load_data
);

    import cache_pkg::*;

    localparam int TAG_W = ADDR_W - 2 - INDEX_BITS;
    localparam int LINES = 1 << INDEX_BITS;

    logic [TAG_W-1:0]      addr_tag;
    logic [INDEX_BITS-1:0] addr_idx;
    logic [1:0]            addr_off;

    logic [LINES-1:0]  valid_bits;
    logic [LINES-1:0]  dirty_bits;
    logic [TAG_W-1:0]  tag_mem  [LINES];
    logic [DATA_W-1:0] data_mem [LINES];

    logic [3:0]        lane_mask;
    logic [DATA_W-1:0] aligned_wdata;

    // tag | index | byte offset
    assign addr_tag = addr[ADDR_W-1 -: TAG_W];
    assign addr_idx = addr[INDEX_BITS+1:2];
    assign addr_off = addr[1:0];

    // store data moved up into its lanes
    assign lane_mask     = apply_size(size, addr_off);
    assign aligned_wdata = wdata << {addr_off, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            if (fill) begin
                valid_bits[addr_idx] <= 1'b1;
                dirty_bits[addr_idx] <= 1'b0;
            end else if (store) begin
                dirty_bits[addr_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we && fill) begin
            tag_mem[addr_idx]  <= addr_tag;
            data_mem[addr_idx] <= wdata;
        end else if (we && store) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_mask[i]) begin
                    data_mem[addr_idx][8*i +: 8] <= aligned_wdata[8*i +: 8];
                end
            end
        end
    end

    // arrays read combinationally so a hit answers in the same cycle
    assign victim_tag = tag_mem[addr_idx];
    assign line_data  = data_mem[addr_idx];
    assign hit        = valid_bits[addr_idx] && (victim_tag == addr_tag);
    assign dirty      = valid_bits[addr_idx] && dirty_bits[addr_idx];

    // loads come back right-justified
    assign load_data = line_data >> {addr_off, 3'b000};

endmodule

//--- design/cache_ctrl.sv
module cache_ctrl #(
    parameter int INDEX_BITS = 4
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  logic [cache_pkg::ADDR_W-1:0]             paddr,
    input  logic [cache_pkg::DATA_W-1:0]             pwdata,
    input  cache_pkg::size_t                         psize,
    output logic [cache_pkg::DATA_W-1:0]             prdata,
    output logic                                     pready,
    output logic                                     pslverr,
    input  logic                                     hit,
    input  logic                                     dirty,
    input  logic [cache_pkg::ADDR_W-3-INDEX_BITS:0]  victim_tag,
    input  logic [cache_pkg::DATA_W-1:0]             line_data,
    input  logic [cache_pkg::DATA_W-1:0]             load_data,
    output logic [cache_pkg::ADDR_W-1:0]             way_addr,
    output cache_pkg::size_t                         way_size,
    output logic [cache_pkg::DATA_W-1:0]             way_wdata,
    output logic                                     way_we,
    output logic                                     way_fill,
    output logic                                     way_store,
    input  logic                                     full,
    input  logic                                     empty,
    output logic                                     push,
    output cache_pkg::evict_t                        push_entry,
    input  logic                                     master_busy,
    output logic                                     refill_req,
    output logic [cache_pkg::ADDR_W-3:0]             refill_addr,
    input  logic                                     refill_done,
    input  logic [cache_pkg::DATA_W-1:0]             refill_data
);

    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        pready     = 1'b0;
        way_fill   = 1'b0;
        way_store  = 1'b0;
        push       = 1'b0;
        refill_req = 1'b0;
        case (state)
            ST_IDLE: begin
                if (psel && !penable) begin
                    next_state = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (psel && penable) begin
                    if (hit) begin
                        pready     = 1'b1;
                        way_store  = pwrite;
                        next_state = ST_IDLE;
                    end else if (dirty) begin
                        next_state = ST_EVICT;
                    end else begin
                        next_state = ST_WAIT_DRAIN;
                    end
                end
            end
            ST_EVICT: begin
                // stays here while the buffer is full
                if (!full) begin
                    push       = 1'b1;
                    next_state = ST_WAIT_DRAIN;
                end
            end
            ST_WAIT_DRAIN: begin
                if (empty && !master_busy) begin
                    next_state = ST_REFILL;
                end
            end
            ST_REFILL: begin
                refill_req = 1'b1;
                if (refill_done) begin
                    // fill lands here, so finish sees a hit
                    way_fill   = 1'b1;
                    next_state = ST_FINISH;
                end
            end
            ST_FINISH: begin
                pready     = 1'b1;
                way_store  = pwrite;
                next_state = ST_IDLE;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    assign way_addr  = paddr;
    assign way_size  = psize;
    assign way_wdata = (state == ST_REFILL) ? refill_data : pwdata;
    assign way_we    = way_fill | way_store;

    // victim word address rebuilt from its tag and our index
    assign push_entry.waddr = {victim_tag, paddr[INDEX_BITS+1:2]};
    assign push_entry.data  = line_data;

    assign refill_addr = paddr[ADDR_W-1:2];

    assign prdata  = load_data;
    assign pslverr = 1'b0;

endmodule

//--- design/evict_buffer.sv
module evict_buffer #(
    parameter int EVICT_DEPTH = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  cache_pkg::evict_t push_entry,
    input  logic              pop,
    output cache_pkg::evict_t head_entry,
    output logic              empty,
    output logic              full
);

    import cache_pkg::*;

    localparam int PTR_W = (EVICT_DEPTH > 1) ? $clog2(EVICT_DEPTH) : 1;
    localparam int CNT_W = $clog2(EVICT_DEPTH + 1);

    evict_t entries [EVICT_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(EVICT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(EVICT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    assign head_entry = entries[rd_ptr];
    assign empty      = (count == '0);
    assign full       = (count == CNT_W'(EVICT_DEPTH));

endmodule

//--- design/mem_master.sv
module mem_master (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_pkg::evict_t            head_entry,
    input  logic                         empty,
    output logic                         pop,
    output logic                         master_busy,
    input  logic                         refill_req,
    input  logic [cache_pkg::ADDR_W-3:0] refill_addr,
    output logic                         refill_done,
    output logic [cache_pkg::DATA_W-1:0] refill_data,
    output logic                         m_psel,
    output logic                         m_penable,
    output logic                         m_pwrite,
    output logic [cache_pkg::ADDR_W-1:0] m_paddr,
    output logic [cache_pkg::DATA_W-1:0] m_pwdata,
    input  logic [cache_pkg::DATA_W-1:0] m_prdata,
    input  logic                         m_pready
);

    import cache_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,
        M_SETUP,
        M_ACCESS
    } m_state_t;

    m_state_t          state;
    logic              write_q;
    logic [ADDR_W-3:0] waddr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= M_IDLE;
            write_q <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    // evictions go out before any refill
                    if (!empty) begin
                        write_q <= 1'b1;
                        state   <= M_SETUP;
                    end else if (refill_req) begin
                        write_q <= 1'b0;
                        state   <= M_SETUP;
                    end
                end
                M_SETUP:  state <= M_ACCESS;
                M_ACCESS: begin
                    if (m_pready) begin
                        state <= M_IDLE;
                    end
                end
                default:  state <= M_IDLE;
            endcase
        end
    end

    // request payload, held until the transfer ends
    always_ff @(posedge clk) begin
        if (state == M_IDLE) begin
            waddr_q <= !empty ? head_entry.waddr : refill_addr;
            wdata_q <= head_entry.data;
        end
    end

    assign done        = (state == M_ACCESS) && m_pready;
    assign pop         = done && write_q;
    assign refill_done = done && !write_q;
    assign refill_data = m_prdata;
    assign master_busy = (state != M_IDLE);

    assign m_psel    = (state != M_IDLE);
    assign m_penable = (state == M_ACCESS);
    assign m_pwrite  = write_q;
    assign m_paddr   = {waddr_q, 2'b00};
    assign m_pwdata  = wdata_q;

endmodule

//--- design/cache_top.sv
module cache_top #(
    parameter int INDEX_BITS  = 4,
    parameter int EVICT_DEPTH = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [cache_pkg::ADDR_W-1:0] paddr,
    input  logic [cache_pkg::DATA_W-1:0] pwdata,
    input  cache_pkg::size_t             psize,
    output logic [cache_pkg::DATA_W-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         m_psel,
    output logic                         m_penable,
    output logic                         m_pwrite,
    output logic [cache_pkg::ADDR_W-1:0] m_paddr,
    output logic [cache_pkg::DATA_W-1:0] m_pwdata,
    input  logic [cache_pkg::DATA_W-1:0] m_prdata,
    input  logic                         m_pready
);

    import cache_pkg::*;

    logic                       hit;
    logic                       dirty;
    logic [ADDR_W-3-INDEX_BITS:0] victim_tag;
    logic [DATA_W-1:0]          line_data;
    logic [DATA_W-1:0]          load_data;
    logic [ADDR_W-1:0]          way_addr;
    size_t                      way_size;
    logic [DATA_W-1:0]          way_wdata;
    logic                       way_we;
    logic                       way_fill;
    logic                       way_store;
    logic                       push;
    evict_t                     push_entry;
    logic                       pop;
    evict_t                     head_entry;
    logic                       empty;
    logic                       full;
    logic                       master_busy;
    logic                       refill_req;
    logic [ADDR_W-3:0]          refill_addr;
    logic                       refill_done;
    logic [DATA_W-1:0]          refill_data;

    cache_ctrl #(
        .INDEX_BITS (INDEX_BITS)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .psize       (psize),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .hit         (hit),
        .dirty       (dirty),
        .victim_tag  (victim_tag),
        .line_data   (line_data),
        .load_data   (load_data),
        .way_addr    (way_addr),
        .way_size    (way_size),
        .way_wdata   (way_wdata),
        .way_we      (way_we),
        .way_fill    (way_fill),
        .way_store   (way_store),
        .full        (full),
        .empty       (empty),
        .push        (push),
        .push_entry  (push_entry),
        .master_busy (master_busy),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_done (refill_done),
        .refill_data (refill_data)
    );

    cache_way #(
        .INDEX_BITS (INDEX_BITS)
    ) u_way (
        .clk        (clk),
        .rst        (rst),
        .addr       (way_addr),
        .size       (way_size),
        .wdata      (way_wdata),
        .we         (way_we),
        .fill       (way_fill),
        .store      (way_store),
        .hit        (hit),
        .dirty      (dirty),
        .victim_tag (victim_tag),
        .line_data  (line_data),
        .load_data  (load_data)
    );

    evict_buffer #(
        .EVICT_DEPTH (EVICT_DEPTH)
    ) u_buffer (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head_entry (head_entry),
        .empty      (empty),
        .full       (full)
    );

    mem_master u_master (
        .clk         (clk),
        .rst         (rst),
        .head_entry  (head_entry),
        .empty       (empty),
        .pop         (pop),
        .master_busy (master_busy),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_done (refill_done),
        .refill_data (refill_data),
        .m_psel      (m_psel),
        .m_penable   (m_penable),
        .m_pwrite    (m_pwrite),
        .m_paddr     (m_paddr),
        .m_pwdata    (m_pwdata),
        .m_prdata    (m_prdata),
        .m_pready    (m_pready)
    );

endmodule

//--- dv/cache_properties.sv
module cache_properties (
    input logic        clk,
    input logic        rst,
    input logic        psel,
    input logic        penable,
    input logic        pready,
    input logic        m_psel,
    input logic        m_pwrite,
    input logic [31:0] m_paddr,
    input logic [31:0] m_pwdata,
    input logic        m_pready,
    input logic        push,
    input logic        full,
    input logic        pop,
    input logic        empty
);

    // memory request held while the completer stalls
    mem_request_held: assert property (
        @(posedge clk) disable iff (rst)
        (m_psel && !m_pready) |=>
            (m_psel && $stable(m_paddr) && $stable(m_pwrite) && $stable(m_pwdata))
    ) else $error("memory request changed during a stall");

    cpu_ready_in_access: assert property (
        @(posedge clk) disable iff (rst)
        pready |-> (psel && penable)
    ) else $error("pready outside an access phase");

    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        push |-> !full
    ) else $error("eviction pushed into a full buffer");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    ) else $error("pop from an empty buffer");

endmodule

//--- dv/tb_top.sv
module tb_top;

    import cache_pkg::*;

    localparam int          PERIOD       = 100;
    localparam int          RESET_CYCLES = 16;
    localparam int          STALL_ROUNDS = 8;
    localparam int          RAND_OPS     = 150;
    localparam int          NUM_XFERS    = 18 + 3 * STALL_ROUNDS + RAND_OPS;
    // generous cycle count for a dirty miss with stalls
    localparam int          MISS_BOUND   = 60;
    localparam int          TIMEOUT_CYC  = RESET_CYCLES + NUM_XFERS * MISS_BOUND;
    localparam logic [31:0] SEED         = 32'hda3a_bd2c;

    logic              clk = 1'b0;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    size_t             psize;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              m_psel;
    logic              m_penable;
    logic              m_pwrite;
    logic [ADDR_W-1:0] m_paddr;
    logic [DATA_W-1:0] m_pwdata;
    logic [DATA_W-1:0] m_prdata = '0;
    logic              m_pready = 1'b0;

    integer stall_seed = SEED;
    integer mix_seed   = SEED;

    // memory model words and reference bytes, both sparse
    logic [31:0] mem [logic [29:0]];
    logic [7:0]  ref_bytes [logic [31:0]];
    int          mem_reads;
    int          mem_writes;
    time         last_write_t = 0;
    time         last_read_t = 0;
    bit          stall_en;

    int checks;
    int errors;
    int test_errors;
    int tests_run;

    cache_top #(
        .INDEX_BITS  (4),
        .EVICT_DEPTH (2)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .psize     (psize),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwrite  (m_pwrite),
        .m_paddr   (m_paddr),
        .m_pwdata  (m_pwdata),
        .m_prdata  (m_prdata),
        .m_pready  (m_pready)
    );

    bind cache_top cache_properties u_props (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pready   (pready),
        .m_psel   (m_psel),
        .m_pwrite (m_pwrite),
        .m_paddr  (m_paddr),
        .m_pwdata (m_pwdata),
        .m_pready (m_pready),
        .push     (push),
        .full     (full),
        .pop      (pop),
        .empty    (empty)
    );

    always #(PERIOD / 2) clk = ~clk;

    // preload pattern, mixes every address bit
    function automatic logic [31:0] pattern_word(input logic [29:0] waddr);
        return (32'(waddr) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] mem_word(input logic [29:0] waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return pattern_word(waddr);
    endfunction

    // memory completer, drives data and stalls after the edge
    always @(posedge clk) begin
        #1;
        if (m_psel) begin
            m_prdata = mem_word(m_paddr[31:2]);
            m_pready = stall_en ? (($random(stall_seed) & 3) != 0) : 1'b1;
        end else begin
            m_pready = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (!rst && m_psel && m_penable && m_pready) begin
            if (m_pwrite) begin
                mem[m_paddr[31:2]] = m_pwdata;
                mem_writes++;
                last_write_t = $time;
            end else begin
                mem_reads++;
                last_read_t = $time;
            end
        end
    end

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [31:0] w;
        if (ref_bytes.exists(a)) begin
            return ref_bytes[a];
        end
        w = pattern_word(a[31:2]);
        return w[{a[1:0], 3'b000} +: 8];
    endfunction

    // loads return the whole word shifted down by the byte offset
    function automatic logic [31:0] ref_read(input logic [31:0] a);
        logic [31:0] base;
        logic [31:0] word;
        base = {a[31:2], 2'b00};
        word = {ref_byte(base + 32'd3), ref_byte(base + 32'd2),
                ref_byte(base + 32'd1), ref_byte(base)};
        return word >> {a[1:0], 3'b000};
    endfunction

    task automatic ref_store(input logic [31:0] addr, input size_t size,
                             input logic [31:0] data);
        int n;
        case (size)
            SIZE_BYTE: n = 1;
            SIZE_HALF: n = 2;
            default:   n = 4;
        endcase
        for (int i = 0; i < n; i++) begin
            ref_bytes[addr + 32'(i)] = data[8*i +: 8];
        end
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    // one CPU transfer, cycles counts access-phase cycles
    task automatic cpu_access(input logic wr, input logic [31:0] addr, input size_t size,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int cycles);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        psize   = size;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!pready);
        rdata = prdata;
        check_eq(32'(pslverr), 32'd0, "pslverr on completion");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_op(input logic [31:0] addr, input size_t size,
                            input logic [31:0] data);
        logic [31:0] rdata;
        int          cycles;
        cpu_access(1'b1, addr, size, data, rdata, cycles);
        ref_store(addr, size, data);
    endtask

    task automatic read_check(input logic [31:0] addr, input size_t size,
                              input string what);
        logic [31:0] rdata;
        int          cycles;
        cpu_access(1'b0, addr, size, '0, rdata, cycles);
        check_eq(rdata, ref_read(addr), what);
    endtask

    task automatic reset_quiet_test();
        logic [31:0] rdata;
        int          cycles;
        int          r0;
        int          w0;
        repeat (4) begin
            @(negedge clk);
            check_eq(32'(pready), 32'd0, "pready while idle");
            check_eq(32'(m_psel), 32'd0, "m_psel while idle");
            check_eq(32'(m_penable), 32'd0, "m_penable while idle");
        end
        r0 = mem_reads;
        w0 = mem_writes;
        cpu_access(1'b0, 32'h0000_0100, SIZE_WORD, '0, rdata, cycles);
        check_eq(rdata, pattern_word(30'h40), "first read data");
        check_eq(32'(mem_reads - r0), 32'd1, "memory reads on first miss");
        check_eq(32'(mem_writes - w0), 32'd0, "memory writes on first miss");
        finish_test("reset_quiet");
    endtask

    task automatic hit_test();
        logic [31:0] rdata;
        int          cycles;
        int          r0;
        int          w0;
        r0 = mem_reads;
        w0 = mem_writes;
        cpu_access(1'b0, 32'h0000_0100, SIZE_WORD, '0, rdata, cycles);
        check_eq(rdata, pattern_word(30'h40), "hit data");
        check_eq(32'(cycles), 32'd1, "hit access cycles");
        check_eq(32'(mem_reads - r0), 32'd0, "memory reads on hit");
        check_eq(32'(mem_writes - w0), 32'd0, "memory writes on hit");
        finish_test("read_hit");
    endtask

    task automatic sub_word_test();
        logic [31:0] base;
        base = 32'h0000_0204;
        for (int off = 0; off < 4; off++) begin
            write_op(base + 32'(off), SIZE_BYTE, 32'hdead_bea0 + 32'(off));
        end
        read_check(base, SIZE_WORD, "word after byte stores");
        for (int off = 0; off < 4; off++) begin
            read_check(base + 32'(off), SIZE_BYTE, "byte load");
        end
        write_op(base, SIZE_HALF, 32'h5555_1234);
        write_op(base + 32'd2, SIZE_HALF, 32'haaaa_cdef);
        read_check(base, SIZE_WORD, "word after half stores");
        read_check(base + 32'd2, SIZE_HALF, "upper half load");
        finish_test("sub_word");
    endtask

    task automatic evict_test();
        logic [31:0] a;
        logic [31:0] b;
        int          r0;
        int          w0;
        // same index 2, different tags
        a = 32'h0000_0308;
        b = 32'h0000_0708;
        write_op(a, SIZE_WORD, 32'h1357_9bdf);
        r0 = mem_reads;
        w0 = mem_writes;
        read_check(b, SIZE_WORD, "conflict read");
        check_eq(32'(mem_writes - w0), 32'd1, "write-backs on dirty miss");
        check_eq(32'(mem_reads - r0), 32'd1, "refills on dirty miss");
        check_eq(32'(last_write_t < last_read_t), 32'd1, "write-back before refill");
        check_eq(mem_word(a[31:2]), 32'h1357_9bdf, "victim word in memory");
        read_check(a, SIZE_WORD, "read back evicted word");
        finish_test("evict");
    endtask

    task automatic stall_test();
        logic [31:0] x;
        logic [31:0] y;
        stall_en = 1'b1;
        for (int i = 0; i < STALL_ROUNDS; i++) begin
            x = 32'h0001_000c + (32'(i) << 8);
            y = x + 32'h0010_0000;
            write_op(x, SIZE_WORD, 32'hc0de_0000 + 32'(i));
            read_check(y, SIZE_WORD, "refill under stalls");
            read_check(x, SIZE_WORD, "write-back under stalls");
        end
        finish_test("stalls");
    endtask

    task automatic random_mix_test();
        logic [31:0] rnd;
        logic [31:0] data;
        logic [31:0] addr;
        logic [1:0]  off;
        size_t       size;
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd  = $random(mix_seed);
            data = $random(mix_seed);
            case (rnd[5:4])
                2'd0: begin
                    size = SIZE_BYTE;
                    off  = rnd[7:6];
                end
                2'd1: begin
                    size = SIZE_HALF;
                    off  = {rnd[7], 1'b0};
                end
                default: begin
                    size = SIZE_WORD;
                    off  = 2'b00;
                end
            endcase
            // four tags over indices 8 to 11
            addr = 32'h0002_0000 | {18'd0, rnd[3:2], 12'd0} | {26'd0, 2'b10, rnd[1:0], off};
            if (rnd[8]) begin
                write_op(addr, size, data);
            end else begin
                read_check(addr, size, "random load");
            end
        end
        finish_test("random_mix");
    endtask

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("timeout after %0d cycles, a transfer never completed", TIMEOUT_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        psize   = SIZE_WORD;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_quiet_test();
        hit_test();
        sub_word_test();
        evict_test();
        stall_test();
        random_mix_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
design/cache_pkg.sv
design/cache_way.sv
design/cache_ctrl.sv
design/evict_buffer.sv
design/mem_master.sv
design/cache_top.sv
dv/cache_properties.sv
dv/tb_top.sv

//--- Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
